//--- src/cpuPkg.sv
////////////////////////////////////////
// RV32I multicycle core definitions
// Widths, opcode and funct codes, and the
// select encodings shared by the datapath
////////////////////////////////////////
`default_nettype none

package cpuPkg;

    // Data and register index widths
    localparam int xlen = 32;
    localparam int regAddrWidth = 5;
    localparam int shamtWidth = $clog2(xlen);

    typedef logic [xlen-1:0] wordT;
    typedef logic [regAddrWidth-1:0] regAddrT;

    // Start address after reset
    localparam wordT resetPc = '0;

    ////////////////////////////////////////
    // Opcodes and funct fields
    ////////////////////////////////////////
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLui    = 7'b0110111;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    // Word access and beq share these slots
    localparam logic [2:0] f3Word   = 3'b010;
    localparam logic [2:0] f3Beq    = 3'b000;
    // Selects sub and sra
    localparam logic [6:0] f7Alt    = 7'b0100000;

    ////////////////////////////////////////
    // Control selects
    ////////////////////////////////////////
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluSlt, aluSltu, aluSll, aluSrl, aluSra
    } aluOpT;

    typedef enum logic [2:0] {immI, immS, immB, immU} immSrcT;
    typedef enum logic [1:0] {srcPc, srcOldPc, srcRegA} srcASelT;
    typedef enum logic [1:0] {srcRegB, srcImm, srcFour} srcBSelT;
    typedef enum logic [1:0] {resAluOut, resMemData, resAluResult, resImm} resultSelT;

endpackage

`default_nettype wire

//--- src/regFile.sv
////////////////////////////////////////
// Register file, 32 x 32 bits
// Two registered read ports, one write
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module regFile import cpuPkg::*; (
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire regAddrT rs1,
    input  wire regAddrT rs2,
    input  wire regAddrT rd,
    input  wire logic    regWrite,
    input  wire wordT    writeData,
    output wordT         readDataA,
    output wordT         readDataB
);

    // Storage, x0 slot never written
    wordT regs [2**regAddrWidth];

    always_ff @(posedge clk) begin
        if (regWrite && (rd != '0)) begin
            regs[rd] <= writeData;
        end
    end

    // Read ports, one cycle latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readDataA <= '0;
            readDataB <= '0;
        end else begin
            readDataA <= (rs1 == '0) ? '0 : regs[rs1];
            readDataB <= (rs2 == '0) ? '0 : regs[rs2];
        end
    end

    // x0 reads back as zero on the following cycle
    assert property (@(posedge clk) disable iff (reset) (rs1 == '0) |=> (readDataA == '0))
        else $error("regFile: x0 read on port A returned nonzero");

endmodule

`default_nettype wire

//--- src/instrDecode.sv
////////////////////////////////////////
// Instruction register and decoder
// Field slicing and immediate generation
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module instrDecode import cpuPkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   irEnable,
    input  wire wordT   instrWord,
    input  wire immSrcT immSrc,
    output logic [6:0]  opcode,
    output logic [2:0]  funct3,
    output logic [6:0]  funct7,
    output regAddrT     rs1,
    output regAddrT     rs2,
    output regAddrT     rd,
    output wordT        immediate
);

    wordT instrReg;
    wordT immIType, immSType, immBType, immUType;

    // Loaded once per instruction, in the cycle after fetch
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instrReg <= '0;
        end else if (irEnable) begin
            instrReg <= instrWord;
        end
    end

    // Fixed RV32 field positions
    assign opcode = instrReg[6:0];
    assign rd     = instrReg[11:7];
    assign funct3 = instrReg[14:12];
    assign rs1    = instrReg[19:15];
    assign rs2    = instrReg[24:20];
    assign funct7 = instrReg[31:25];

    // Sign bit is always instr[31]
    assign immIType = {{20{instrReg[31]}}, instrReg[31:20]};
    assign immSType = {{20{instrReg[31]}}, instrReg[31:25], instrReg[11:7]};
    assign immBType = {{19{instrReg[31]}}, instrReg[31], instrReg[7],
                       instrReg[30:25], instrReg[11:8], 1'b0};
    assign immUType = {instrReg[31:12], 12'b0};

    always_comb begin
        case (immSrc)
            immS:    immediate = immSType;
            immB:    immediate = immBType;
            immU:    immediate = immUType;
            default: immediate = immIType;
        endcase
    end

endmodule

`default_nettype wire

//--- src/alu.sv
////////////////////////////////////////
// Arithmetic and logic unit
// Ten RV32I operations plus a zero flag
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module alu import cpuPkg::*; (
    input  wire wordT  a,
    input  wire wordT  b,
    input  wire aluOpT aluOp,
    output wordT       result,
    output logic       zero
);

    // Shift amount from the low bits of b
    logic [shamtWidth-1:0] shamt;
    assign shamt = b[shamtWidth-1:0];

    always_comb begin
        case (aluOp)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            // Compares yield 0 or 1
            aluSlt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            aluSltu: result = {{(xlen-1){1'b0}}, a < b};
            aluSll:  result = a << shamt;
            aluSrl:  result = a >> shamt;
            aluSra:  result = $signed(a) >>> shamt;
            default: result = a + b;
        endcase
    end

    // Used by beq after a subtract
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- src/controlFsm.sv
////////////////////////////////////////
// Multicycle control state machine
// Drives every datapath select and enable
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module controlFsm import cpuPkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [6:0] opcode,
    input  wire logic [2:0] funct3,
    input  wire logic [6:0] funct7,
    input  wire logic       zero,
    output logic            pcEnable,
    output logic            oldPcEnable,
    output logic            irEnable,
    output logic            instrOrData,
    output immSrcT          immSrc,
    output srcASelT         aluSrcA,
    output srcBSelT         aluSrcB,
    output aluOpT           aluOp,
    output resultSelT       resultSrc,
    output logic            memWrite,
    output logic            regWrite
);

    typedef enum logic [3:0] {
        sFetch, sIrLoad, sDecode, sExecute, sAluWb, sLuiWb,
        sBranch, sMemAddr, sMemRead, sMemWb, sMemStore
    } stateT;

    stateT state, nextState;
    logic  isAluReg, isAluImm, isLoad, isStore, isBeq, isLui;
    aluOpT execOp;

    // Supported instruction classes
    assign isAluReg = (opcode == opOp);
    assign isAluImm = (opcode == opOpImm);
    assign isLoad   = (opcode == opLoad) && (funct3 == f3Word);
    assign isStore  = (opcode == opStore) && (funct3 == f3Word);
    assign isBeq    = (opcode == opBranch) && (funct3 == f3Beq);
    assign isLui    = (opcode == opLui);

    // ALU op from funct fields, addi never subtracts
    always_comb begin
        case (funct3)
            f3AddSub: execOp = (isAluReg && (funct7 == f7Alt)) ? aluSub : aluAdd;
            f3Sll:    execOp = aluSll;
            f3Slt:    execOp = aluSlt;
            f3Sltu:   execOp = aluSltu;
            f3Xor:    execOp = aluXor;
            f3SrlSra: execOp = (funct7 == f7Alt) ? aluSra : aluSrl;
            f3Or:     execOp = aluOr;
            f3And:    execOp = aluAnd;
            default:  execOp = aluAdd;
        endcase
    end

    ////////////////////////////////////////
    // State register and sequencing
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= sFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = sFetch;
        case (state)
            sFetch:   nextState = sIrLoad;
            sIrLoad:  nextState = sDecode;
            sDecode: begin
                // Anything unsupported drops back to fetch
                if (isAluReg || isAluImm) begin
                    nextState = sExecute;
                end else if (isLui) begin
                    nextState = sLuiWb;
                end else if (isBeq) begin
                    nextState = sBranch;
                end else if (isLoad || isStore) begin
                    nextState = sMemAddr;
                end
            end
            sExecute: nextState = sAluWb;
            sMemAddr: nextState = isLoad ? sMemRead : sMemStore;
            sMemRead: nextState = sMemWb;
            default:  nextState = sFetch;
        endcase
    end

    ////////////////////////////////////////
    // Per-state outputs
    ////////////////////////////////////////
    always_comb begin
        pcEnable    = 1'b0;
        oldPcEnable = 1'b0;
        irEnable    = 1'b0;
        instrOrData = 1'b0;
        immSrc      = immI;
        aluSrcA     = srcRegA;
        aluSrcB     = srcRegB;
        aluOp       = aluAdd;
        resultSrc   = resAluOut;
        memWrite    = 1'b0;
        regWrite    = 1'b0;
        case (state)
            sFetch: begin
                // PC + 4 straight from the ALU
                aluSrcA     = srcPc;
                aluSrcB     = srcFour;
                resultSrc   = resAluResult;
                pcEnable    = 1'b1;
                oldPcEnable = 1'b1;
            end
            sIrLoad: irEnable = 1'b1;
            sDecode: begin
                // Branch target lands in aluOut
                immSrc  = immB;
                aluSrcA = srcOldPc;
                aluSrcB = srcImm;
            end
            sExecute: begin
                aluSrcB = isAluImm ? srcImm : srcRegB;
                aluOp   = execOp;
            end
            sAluWb: regWrite = 1'b1;
            sLuiWb: begin
                immSrc    = immU;
                resultSrc = resImm;
                regWrite  = 1'b1;
            end
            sBranch: begin
                // Taken when rs1 - rs2 is zero, target from aluOut
                aluOp    = aluSub;
                pcEnable = zero;
            end
            sMemAddr: begin
                // Address goes out combinationally, data back next cycle
                immSrc      = isStore ? immS : immI;
                aluSrcB     = srcImm;
                resultSrc   = resAluResult;
                instrOrData = 1'b1;
            end
            sMemWb: begin
                resultSrc = resMemData;
                regWrite  = 1'b1;
            end
            sMemStore: begin
                instrOrData = 1'b1;
                memWrite    = 1'b1;
            end
            default: begin
                // sMemRead only waits for the memory data register
                aluOp = aluAdd;
            end
        endcase
    end

    assert property (@(posedge clk) disable iff (reset) !(memWrite && regWrite))
        else $error("controlFsm: memWrite and regWrite both high");

    assert property (@(posedge clk) disable iff (reset) state inside {[sFetch:sMemStore]})
        else $error("controlFsm: illegal state");

endmodule

`default_nettype wire

//--- src/cpuCore.sv
////////////////////////////////////////
// RV32I multicycle core, top level
// One shared memory port, byte-swapped bus
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module cpuCore import cpuPkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire wordT memReadData,
    output wordT      memAddress,
    output wordT      memWriteData,
    output logic      memWrite
);

    // Control
    logic      pcEnable, oldPcEnable, irEnable, instrOrData, regWrite, zero;
    immSrcT    immSrc;
    srcASelT   aluSrcA;
    srcBSelT   aluSrcB;
    aluOpT     aluOp;
    resultSelT resultSrc;

    // Decoded fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    regAddrT    rs1, rs2, rd;
    wordT       immediate;

    // Datapath
    wordT pc, oldPc, aluOut, memData, readWord;
    wordT readDataA, readDataB, srcA, srcB, aluResult, result;

    // Bus words arrive with bytes reversed
    function automatic wordT byteSwap(input wordT word);
        return {word[7:0], word[15:8], word[23:16], word[31:24]};
    endfunction

    assign readWord     = byteSwap(memReadData);
    assign memWriteData = byteSwap(readDataB);

    ////////////////////////////////////////
    // Architectural and holding registers
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc    <= resetPc;
            oldPc <= resetPc;
        end else begin
            if (pcEnable) begin
                pc <= result;
            end
            if (oldPcEnable) begin
                oldPc <= pc;
            end
        end
    end

    // Loaded every cycle, read one state later
    always_ff @(posedge clk) begin
        aluOut  <= aluResult;
        memData <= readWord;
    end

    ////////////////////////////////////////
    // Multiplexers
    ////////////////////////////////////////
    always_comb begin
        case (aluSrcA)
            srcPc:    srcA = pc;
            srcOldPc: srcA = oldPc;
            default:  srcA = readDataA;
        endcase
        case (aluSrcB)
            srcImm:  srcB = immediate;
            srcFour: srcB = 32'd4;
            default: srcB = readDataB;
        endcase
        case (resultSrc)
            resMemData:   result = memData;
            resAluResult: result = aluResult;
            resImm:       result = immediate;
            default:      result = aluOut;
        endcase
    end

    // Instruction fetch from PC, data access from result
    assign memAddress = instrOrData ? result : pc;

    controlFsm controlFsmInst (
        .clk(clk), .reset(reset),
        .opcode(opcode), .funct3(funct3), .funct7(funct7), .zero(zero),
        .pcEnable(pcEnable), .oldPcEnable(oldPcEnable), .irEnable(irEnable),
        .instrOrData(instrOrData), .immSrc(immSrc),
        .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluOp(aluOp),
        .resultSrc(resultSrc), .memWrite(memWrite), .regWrite(regWrite)
    );

    instrDecode instrDecodeInst (
        .clk(clk), .reset(reset), .irEnable(irEnable),
        .instrWord(readWord), .immSrc(immSrc),
        .opcode(opcode), .funct3(funct3), .funct7(funct7),
        .rs1(rs1), .rs2(rs2), .rd(rd), .immediate(immediate)
    );

    regFile regFileInst (
        .clk(clk), .reset(reset),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .regWrite(regWrite), .writeData(result),
        .readDataA(readDataA), .readDataB(readDataB)
    );

    alu aluInst (
        .a(srcA), .b(srcB), .aluOp(aluOp),
        .result(aluResult), .zero(zero)
    );

endmodule

`default_nettype wire

//--- verif/cpuProgram.svh
////////////////////////////////////////
// Test program for the multicycle core
// RV32I encoders and the program builder
////////////////////////////////////////
`ifndef CPU_PROGRAM_SVH
`define CPU_PROGRAM_SVH

// Random operands, one pair per ALU op
logic [31:0] operandA [10];
logic [31:0] operandB [10];
logic [11:0] storeOffset;

function automatic logic [31:0] regOpWord(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] immOpWord(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic logic [31:0] lwWord(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
endfunction

function automatic logic [31:0] swWord(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

// Offset is relative to the beq itself
function automatic logic [31:0] beqWord(input logic [4:0] rs1, input logic [4:0] rs2,
                                        input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] luiWord(input logic [4:0] rd, input logic [19:0] upper);
    return {upper, rd, 7'b0110111};
endfunction

function automatic logic [2:0] funct3For(input logic [3:0] op);
    case (op)
        idxAnd:         return 3'b111;
        idxOr:          return 3'b110;
        idxXor:         return 3'b100;
        idxSlt:         return 3'b010;
        idxSltu:        return 3'b011;
        idxSll:         return 3'b001;
        idxSrl, idxSra: return 3'b101;
        default:        return 3'b000;
    endcase
endfunction

// sub and sra carry funct7 = 0100000
function automatic logic usesAltFunct7(input logic [3:0] op);
    return (op == idxSub) || (op == idxSra);
endfunction

task automatic placeInstr(input logic [31:0] word);
    mem[progLen[7:0]] = busOrder(word);
    progLen++;
endtask

// Store through base x3 into the next slot
task automatic storeAndExpect(input logic [4:0] rs2, input logic [31:0] value);
    placeInstr(swWord(rs2, 5'd3, storeOffset));
    expAddr.push_back(storeBase + {20'b0, storeOffset});
    expData.push_back(value);
    storeOffset += 12'd4;
endtask

// lui plus addi, upper part rounded for the signed low half
task automatic setReg(input logic [4:0] rd, input logic [31:0] value);
    placeInstr(luiWord(rd, value[31:12] + {19'b0, value[11]}));
    placeInstr(immOpWord(3'b000, rd, rd, value[11:0]));
endtask

task automatic buildProgram();
    logic [3:0]  k;
    logic [11:0] imm;
    logic [11:0] loadOffset;
    logic [19:0] upper;
    logic [31:0] value;
    progLen = 0;
    storeOffset = 12'd0;
    placeInstr(immOpWord(3'b000, 5'd3, 5'd0, storeBase[11:0]));
    ////////////////////////////////////////
    // ALU ops, register then immediate form
    ////////////////////////////////////////
    for (k = 4'd0; k < 4'd10; k++) begin
        operandA[k] = $random(seed);
        operandB[k] = $random(seed);
        setReg(5'd1, operandA[k]);
        setReg(5'd2, operandB[k]);
        placeInstr(regOpWord(usesAltFunct7(k) ? 7'b0100000 : 7'b0000000, funct3For(k),
                             5'd4, 5'd1, 5'd2));
        storeAndExpect(5'd4, aluRef(k, operandA[k], operandB[k]));
        // No subi in RV32I
        if (k != idxSub) begin
            imm = 12'(operandB[k]);
            if (k >= idxSll) begin
                imm = {usesAltFunct7(k) ? 7'b0100000 : 7'b0000000, operandB[k][4:0]};
            end
            placeInstr(immOpWord(funct3For(k), 5'd4, 5'd1, imm));
            storeAndExpect(5'd4, aluRef(k, operandA[k], {{20{imm[11]}}, imm}));
        end
    end
    // lui leaves the low twelve bits clear
    upper = 20'($random(seed));
    placeInstr(luiWord(5'd5, upper));
    storeAndExpect(5'd5, {upper, 12'h000});
    // Store, reload, bump, store again
    value = $random(seed);
    imm = 12'($random(seed));
    setReg(5'd1, value);
    loadOffset = storeOffset;
    storeAndExpect(5'd1, value);
    placeInstr(lwWord(5'd6, 5'd3, loadOffset));
    placeInstr(immOpWord(3'b000, 5'd6, 5'd6, imm));
    storeAndExpect(5'd6, aluRef(idxAdd, value, {{20{imm[11]}}, imm}));
    // Taken beq skips the first marker store, not-taken one keeps the second
    placeInstr(immOpWord(3'b000, 5'd7, 5'd0, 12'h5a5));
    placeInstr(beqWord(5'd7, 5'd7, 13'd8));
    placeInstr(swWord(5'd7, 5'd3, storeOffset));
    placeInstr(beqWord(5'd7, 5'd0, 13'd8));
    storeAndExpect(5'd7, 32'h0000_05a5);
    // x0 ignores the write
    placeInstr(immOpWord(3'b000, 5'd0, 5'd0, 12'h123));
    storeAndExpect(5'd0, 32'h0);
    placeInstr(beqWord(5'd0, 5'd0, 13'd0));
endtask

`endif

//--- verif/cpuTb.sv
////////////////////////////////////////
// Testbench for the multicycle core
// Memory model, store checker, timeout
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module cpuTb;

    // Op indices for the reference model
    localparam logic [3:0] idxAdd  = 4'd0;
    localparam logic [3:0] idxSub  = 4'd1;
    localparam logic [3:0] idxAnd  = 4'd2;
    localparam logic [3:0] idxOr   = 4'd3;
    localparam logic [3:0] idxXor  = 4'd4;
    localparam logic [3:0] idxSlt  = 4'd5;
    localparam logic [3:0] idxSltu = 4'd6;
    localparam logic [3:0] idxSll  = 4'd7;
    localparam logic [3:0] idxSrl  = 4'd8;
    localparam logic [3:0] idxSra  = 4'd9;
    // Data area above the program
    localparam logic [31:0] storeBase = 32'h0000_0200;

    logic        clk;
    logic        reset;
    logic [31:0] memReadData;
    logic [31:0] memAddress;
    logic [31:0] memWriteData;
    logic        memWrite;

    // Words kept in bus byte order
    logic [31:0] mem [256];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    integer      seed;
    int          progLen;
    int          cycleCount;
    int          cycleLimit;
    int          checkErrors;
    int          mainErrors;
    logic [7:0]  busAddr;
    logic        busWrite;
    logic [31:0] busWData;
    logic [31:0] wantAddr;
    logic [31:0] wantData;

    function automatic logic [31:0] busOrder(input logic [31:0] word);
        return {word[7:0], word[15:8], word[23:16], word[31:24]};
    endfunction

    // Expected result of one RV32I ALU op
    function automatic logic [31:0] aluRef(input logic [3:0] op, input logic [31:0] a,
                                           input logic [31:0] b);
        case (op)
            idxSub:  return a - b;
            idxAnd:  return a & b;
            idxOr:   return a | b;
            idxXor:  return a ^ b;
            idxSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            idxSltu: return (a < b) ? 32'd1 : 32'd0;
            idxSll:  return a << b[4:0];
            idxSrl:  return a >> b[4:0];
            idxSra:  return $signed(a) >>> b[4:0];
            default: return a + b;
        endcase
    endfunction

    `include "cpuProgram.svh"

    task automatic fillMemory();
        int i;
        for (i = 0; i < 256; i++) begin
            mem[i[7:0]] = {24'hbad000, i[7:0]};
        end
    endtask

    cpuCore cpuCore_inst (
        .clk(clk), .reset(reset), .memReadData(memReadData),
        .memAddress(memAddress), .memWriteData(memWriteData), .memWrite(memWrite)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////
    // Memory model, one-cycle read latency
    ////////////////////////////////////////
    always @(negedge clk) begin
        busAddr  = memAddress[9:2];
        busWrite = memWrite && !reset;
        busWData = memWriteData;
    end

    always @(posedge clk) begin
        #1;
        if (busWrite) begin
            mem[busAddr] = busWData;
        end
        memReadData = mem[busAddr];
    end

    // Store checker, mid-cycle sampling
    always @(negedge clk) begin
        if (!reset && memWrite) begin
            assert (expAddr.size() != 0) else begin
                checkErrors++;
                $display("Unexpected store to address %h after the last expected one",
                         memAddress);
            end
            if (expAddr.size() != 0) begin
                wantAddr = expAddr.pop_front();
                wantData = expData.pop_front();
                assert (memAddress == wantAddr) else begin
                    checkErrors++;
                    $display("MISMATCH memAddress: got %h expected %h", memAddress, wantAddr);
                end
                assert (memWriteData == busOrder(wantData)) else begin
                    checkErrors++;
                    $display("MISMATCH memWriteData: got %h expected %h", memWriteData,
                             busOrder(wantData));
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            cycleCount++;
        end
    end

    initial begin
        seed        = 32'hbcd5;
        reset       = 1'b1;
        memReadData = '0;
        busAddr     = '0;
        busWrite    = 1'b0;
        busWData    = '0;
        mainErrors  = 0;
        fillMemory();
        buildProgram();
        // Six cycles covers the longest instruction
        cycleLimit = progLen * 6 + 50;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        // First fetch from the reset address
        @(negedge clk);
        assert (memAddress == 32'h0) else begin
            mainErrors++;
            $display("MISMATCH memAddress: got %h expected %h", memAddress, 32'h0);
        end
        assert (memWrite == 1'b0) else begin
            mainErrors++;
            $display("MISMATCH memWrite: got %h expected %h", memWrite, 1'b0);
        end
        while (expAddr.size() != 0 && cycleCount < cycleLimit) begin
            @(posedge clk);
        end
        // Two turns of the closing four-cycle beq loop, no store may follow
        repeat (8) @(posedge clk);
        if (expAddr.size() != 0) begin
            mainErrors++;
            $display("Timeout after %0d cycles with %0d expected stores never seen",
                     cycleCount, expAddr.size());
        end
        $display("Error counts: %0d in store checks, %0d in startup and completion",
                 checkErrors, mainErrors);
        if (checkErrors == 0 && mainErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verif
src/cpuPkg.sv
src/regFile.sv
src/instrDecode.sv
src/alu.sv
src/controlFsm.sv
src/cpuCore.sv
verif/cpuTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module cpuTb -f compile.f -o cpuSim
./obj_dir/cpuSim | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
